// File: source/slot_bus_pkg.sv
package slot_bus_pkg;

	// ========================================
	// bus widths
	// ========================================
	localparam int ADDR_W = 16;	// cpu address bus
	localparam int DATA_W = 8;	// cpu data bus

	// ========================================
	// page and slot numbers
	// ========================================
	typedef logic [1:0] page_t;	// 16 KB page of the 64 KB space
	typedef logic [1:0] slot_t;	// primary slot 0..3

	localparam slot_t RAM_SLOT = 2'd3;	// slot 3 holds the ram

	// ========================================
	// address views
	// ========================================
	typedef struct packed {
		logic [ADDR_W/2-1:0] hi;	// upper byte, ignored by port decode
		logic [ADDR_W/2-1:0] port;	// i/o port number
	} io_view_t;

	typedef struct packed {
		page_t              page;	// a15..a14
		logic [ADDR_W-3:0]  offset;	// byte within the page
	} mem_view_t;

	// same address word seen by io cycles and by memory cycles
	typedef union packed {
		io_view_t  io;
		mem_view_t mem;
	} bus_addr_u;

endpackage

// File: source/io_map_pkg.sv
package io_map_pkg;

	// ========================================
	// i/o port map
	// ========================================
	localparam logic [7:0] PORT_LED      = 8'h00;	// led latch, write only
	localparam logic [7:0] PORT_TICK     = 8'h01;	// 100 us counter
	localparam logic [7:0] PORT_VOL      = 8'h06;	// mixer volume
	localparam logic [7:0] PORT_PSG_ADDR = 8'hA0;	// psg address latch
	localparam logic [7:0] PORT_SLOT     = 8'hA8;	// primary slot select

	// ========================================
	// reset values and defaults
	// ========================================
	localparam logic [7:0] VOL_RESET = 8'd15;	// mid volume at power up
	localparam logic [7:0] RD_MISS   = 8'hFF;	// open bus value

	// clocks per 100 us tick at 71.6 MHz
	localparam int TICK_DIV_DEFAULT = 7159;

	// ========================================
	// psg wait timing in clocks
	// ========================================
	localparam int PSG_BUSY_LEN    = 59;	// bus held busy
	localparam int PSG_HOLDOFF_LEN = 27;	// no new wait in this window

endpackage

// File: source/bus_access_if.sv
`timescale 1ns/1ps

interface bus_access_if;
	import slot_bus_pkg::*;

	logic              io_wr;	// one clock pulse per io write
	logic              io_rd;	// one clock pulse per io read
	logic              mem;	// memory cycle level
	bus_addr_u         addr;	// registered address
	logic [DATA_W-1:0] wdata;	// registered write data
	logic [DATA_W-1:0] slot_rd_data;	// A8h value for the read mux

	modport src (
		output io_wr,
		output io_rd,
		output mem,
		output addr,
		output wdata,
		output slot_rd_data
	);

	modport dst (
		input io_wr,
		input io_rd,
		input mem,
		input addr,
		input wdata,
		input slot_rd_data
	);

endinterface

// File: source/bus_capture.sv
`timescale 1ns/1ps

module bus_capture (
	input  logic                              i_CLK,
	input  logic                              i_RST_n,
	input  logic                              i_iorq,
	input  logic                              i_merq,
	input  logic                              i_rd,
	input  logic                              i_wr,
	input  slot_bus_pkg::bus_addr_u           i_addr,
	input  logic [slot_bus_pkg::DATA_W-1:0]   i_wdata,
	bus_access_if.src                         o_acc
);

	logic io_rd_lvl;	// io read seen this clock
	logic io_wr_lvl;	// io write seen this clock
	logic io_rd_prev;	// level at the last edge
	logic io_wr_prev;

	assign io_rd_lvl = i_iorq & i_rd;
	assign io_wr_lvl = i_iorq & i_wr;

	// ========================================
	// strobe edges
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			io_rd_prev  <= 1'b0;
			io_wr_prev  <= 1'b0;
			o_acc.io_rd <= 1'b0;
			o_acc.io_wr <= 1'b0;
			o_acc.mem   <= 1'b0;
		end else begin
			io_rd_prev  <= io_rd_lvl;
			io_wr_prev  <= io_wr_lvl;
			o_acc.io_rd <= io_rd_lvl & ~io_rd_prev;	// rising edge only
			o_acc.io_wr <= io_wr_lvl & ~io_wr_prev;
			o_acc.mem   <= i_merq;	// memory decode runs on the level
		end
	end

	// ========================================
	// payload
	// ========================================
	always_ff @(posedge i_CLK) begin
		o_acc.addr  <= i_addr;
		o_acc.wdata <= i_wdata;
	end

	// slot readback joins in the mapper stage
	assign o_acc.slot_rd_data = '0;

endmodule

// File: source/slot_mapper.sv
`timescale 1ns/1ps

module slot_mapper (
	input  logic                 i_CLK,
	input  logic                 i_RST_n,
	bus_access_if.dst            i_acc,
	bus_access_if.src            o_acc,
	output slot_bus_pkg::slot_t  o_page_slot,
	output logic                 o_ram_sel
);
	import slot_bus_pkg::*;
	import io_map_pkg::*;

	slot_t [3:0] page_slot;	// field n selects the slot of page n
	slot_t       cur_slot;	// slot of the addressed page
	logic        slot_wr;

	assign slot_wr  = i_acc.io_wr && (i_acc.addr.io.port == PORT_SLOT);
	assign cur_slot = page_slot[i_acc.addr.mem.page];

	// ========================================
	// primary slot register
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			page_slot <= '0;	// all pages in slot 0
		end else if (slot_wr) begin
			page_slot <= i_acc.wdata;	// page 3 in bits 7:6
		end
	end

	// ========================================
	// page decode
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			o_page_slot <= '0;
			o_ram_sel   <= 1'b0;
		end else begin
			o_page_slot <= cur_slot;
			o_ram_sel   <= i_acc.mem && (cur_slot == RAM_SLOT);	// slot 3 ram
		end
	end

	// ========================================
	// forward to the register stage
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			o_acc.io_wr <= 1'b0;
			o_acc.io_rd <= 1'b0;
			o_acc.mem   <= 1'b0;
		end else begin
			o_acc.io_wr <= i_acc.io_wr;
			o_acc.io_rd <= i_acc.io_rd;
			o_acc.mem   <= i_acc.mem;
		end
	end

	always_ff @(posedge i_CLK) begin
		o_acc.addr         <= i_acc.addr;
		o_acc.wdata        <= i_acc.wdata;
		o_acc.slot_rd_data <= page_slot;	// readback of A8h
	end

endmodule

// File: source/io_registers.sv
`timescale 1ns/1ps

module io_registers #(
	parameter int TICK_DIV = io_map_pkg::TICK_DIV_DEFAULT
) (
	input  logic                             i_CLK,
	input  logic                             i_RST_n,
	bus_access_if.dst                        i_acc,
	output logic [slot_bus_pkg::DATA_W-1:0]  o_rdata,
	output logic                             o_rd_valid,
	output logic [5:0]                       o_led,
	output logic [slot_bus_pkg::DATA_W-1:0]  o_mixvol
);
	import slot_bus_pkg::*;
	import io_map_pkg::*;

	localparam int PRE_W = $clog2(TICK_DIV + 1);	// prescaler width

	logic [5:0]        led_sts;	// stored as written
	logic [DATA_W-1:0] vol_reg;
	logic [PRE_W-1:0]  presc;	// clocks within one tick
	logic [7:0]        tick_cnt;	// ticks since last clear
	logic [DATA_W-1:0] rd_sel;
	logic [7:0]        port;
	logic              tick_clr;

	assign port     = i_acc.addr.io.port;
	assign tick_clr = i_acc.io_wr && (port == PORT_TICK);

	// leds are driven low active
	assign o_led    = ~led_sts;
	assign o_mixvol = vol_reg;

	// ========================================
	// led and volume
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			led_sts <= '0;
			vol_reg <= VOL_RESET;
		end else if (i_acc.io_wr) begin
			if (port == PORT_LED) begin
				led_sts <= i_acc.wdata[5:0];	// upper bits unused
			end
			if (port == PORT_VOL) begin
				vol_reg <= i_acc.wdata;
			end
		end
	end

	// ========================================
	// 100 us counter
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			presc    <= '0;
			tick_cnt <= '0;
		end else if (tick_clr) begin
			presc    <= '0;	// restart the tick phase too
			tick_cnt <= '0;
		end else if (presc == PRE_W'(TICK_DIV - 1)) begin
			presc <= '0;
			if (tick_cnt != 8'hFF) begin
				tick_cnt <= tick_cnt + 8'd1;	// stops at FFh
			end
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// ========================================
	// read return
	// ========================================
	always_comb begin
		case (port)
			PORT_TICK: rd_sel = tick_cnt;
			PORT_VOL:  rd_sel = vol_reg;
			PORT_SLOT: rd_sel = i_acc.slot_rd_data;
			default:   rd_sel = RD_MISS;	// unmapped or write only
		endcase
	end

	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			o_rd_valid <= 1'b0;
		end else begin
			o_rd_valid <= i_acc.io_rd;	// single pulse per read
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_acc.io_rd) begin
			o_rdata <= rd_sel;
		end
	end

endmodule

// File: source/psg_wait_gen.sv
`timescale 1ns/1ps

module psg_wait_gen (
	input  logic       i_CLK,
	input  logic       i_RST_n,
	bus_access_if.dst  i_acc,
	output logic       o_busy
);
	import io_map_pkg::*;

	localparam int CNT_W = $clog2(PSG_BUSY_LEN);	// busy phase is the longer one

	logic [CNT_W-1:0] cnt;	// clocks left in current phase
	logic             holdoff;	// wait may not restart
	logic             psg_wr;

	assign psg_wr = i_acc.io_wr && (i_acc.addr.io.port == PORT_PSG_ADDR);

	// ========================================
	// busy then holdoff
	// ========================================
	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			cnt     <= '0;
			o_busy  <= 1'b0;
			holdoff <= 1'b0;
		end else if (o_busy) begin
			if (cnt == '0) begin
				o_busy  <= 1'b0;
				holdoff <= 1'b1;
				cnt     <= CNT_W'(PSG_HOLDOFF_LEN - 1);
			end else begin
				cnt <= cnt - 1'b1;
			end
		end else if (holdoff) begin
			if (cnt == '0) begin
				holdoff <= 1'b0;	// idle again
			end else begin
				cnt <= cnt - 1'b1;
			end
		end else if (psg_wr) begin
			o_busy <= 1'b1;	// only from idle
			cnt    <= CNT_W'(PSG_BUSY_LEN - 1);
		end
	end

endmodule

// File: source/basic_slot_unit.sv
`timescale 1ns/1ps

module basic_slot_unit #(
	parameter int TICK_DIV = io_map_pkg::TICK_DIV_DEFAULT
) (
	input  logic                             i_CLK,
	input  logic                             i_RST_n,
	input  logic                             i_iorq,
	input  logic                             i_merq,
	input  logic                             i_rd,
	input  logic                             i_wr,
	input  logic [slot_bus_pkg::ADDR_W-1:0]  i_addr,
	input  logic [slot_bus_pkg::DATA_W-1:0]  i_wdata,
	output logic [slot_bus_pkg::DATA_W-1:0]  o_rdata,
	output logic                             o_rd_valid,
	output logic                             o_busy,
	output logic                             o_ram_sel,
	output slot_bus_pkg::slot_t              o_page_slot,
	output logic [5:0]                       o_led,
	output logic [slot_bus_pkg::DATA_W-1:0]  o_mixvol
);

	bus_access_if acc_a ();	// capture to mapper and psg wait
	bus_access_if acc_b ();	// mapper to registers

	// ========================================
	// pipeline stages
	// ========================================
	bus_capture u_capture (
		.i_CLK   (i_CLK),
		.i_RST_n (i_RST_n),
		.i_iorq  (i_iorq),
		.i_merq  (i_merq),
		.i_rd    (i_rd),
		.i_wr    (i_wr),
		.i_addr  (i_addr),	// viewed as union from here on
		.i_wdata (i_wdata),
		.o_acc   (acc_a)
	);

	slot_mapper u_mapper (
		.i_CLK       (i_CLK),
		.i_RST_n     (i_RST_n),
		.i_acc       (acc_a),
		.o_acc       (acc_b),
		.o_page_slot (o_page_slot),
		.o_ram_sel   (o_ram_sel)
	);

	io_registers #(
		.TICK_DIV (TICK_DIV)
	) u_io_regs (
		.i_CLK      (i_CLK),
		.i_RST_n    (i_RST_n),
		.i_acc      (acc_b),
		.o_rdata    (o_rdata),
		.o_rd_valid (o_rd_valid),
		.o_led      (o_led),
		.o_mixvol   (o_mixvol)
	);

	// busy starts one stage early
	psg_wait_gen u_psg_wait (
		.i_CLK   (i_CLK),
		.i_RST_n (i_RST_n),
		.i_acc   (acc_a),
		.o_busy  (o_busy)
	);

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 3
) (
	output logic o_CLK,
	output logic o_RST_n
);

	initial begin
		o_CLK   = 1'b0;
		o_RST_n = 1'b0;	// held through the first edges
		repeat (RST_CYCLES) @(posedge o_CLK);
		#1 o_RST_n = 1'b1;	// released just after an edge
	end

	always #(PERIOD_NS / 2) o_CLK = ~o_CLK;

endmodule

// File: tests/basic_slot_unit_assert.sv
`timescale 1ns/1ps

module basic_slot_unit_assert (
	input logic i_CLK,
	input logic i_RST_n,
	input logic i_merq,
	input logic i_rd_valid,
	input logic i_busy,
	input logic i_ram_sel
);
	import io_map_pkg::*;

	int busy_run;	// clocks o_busy sampled high in a row

	always_ff @(posedge i_CLK) begin
		if (!i_RST_n) begin
			busy_run <= 0;
		end else if (i_busy) begin
			busy_run <= busy_run + 1;
		end else begin
			busy_run <= 0;
		end
	end

	// ========================================
	// output rules
	// ========================================
	a_rd_valid_pulse: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
		i_rd_valid |=> !i_rd_valid)
		else $error("o_rd_valid stayed high for more than one clock");

	a_busy_len: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
		busy_run <= PSG_BUSY_LEN)
		else $error("o_busy stayed high longer than the psg wait");

	// merq enters two edges before the decode shows up
	a_ram_sel_merq: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
		i_ram_sel |-> $past(i_merq, 2))
		else $error("o_ram_sel high without a memory cycle");

endmodule

bind basic_slot_unit basic_slot_unit_assert u_assert (
	.i_CLK      (i_CLK),
	.i_RST_n    (i_RST_n),
	.i_merq     (i_merq),
	.i_rd_valid (o_rd_valid),
	.i_busy     (o_busy),
	.i_ram_sel  (o_ram_sel)
);

// File: tests/tb_basic_slot_unit.sv
`timescale 1ns/1ps

module tb_basic_slot_unit;
	import slot_bus_pkg::*;

	// ========================================
	// table layout
	// ========================================
	localparam logic [2:0] OP_WR   = 3'd0;	// io write and a wait for the pipe
	localparam logic [2:0] OP_RD   = 3'd1;	// io read checked on o_rdata
	localparam logic [2:0] OP_LED  = 3'd2;
	localparam logic [2:0] OP_VOL  = 3'd3;
	localparam logic [2:0] OP_MEM  = 3'd4;	// exp = {ram_sel, slot}
	localparam logic [2:0] OP_IDLE = 3'd5;	// arg = clocks
	localparam logic [2:0] OP_PSG  = 3'd6;	// exp = busy clocks

	localparam int NROWS       = 24;
	localparam int WATCHDOG_NS = NROWS * 200 * 100;	// 200 clocks per row

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] arg;	// port, address or idle clocks
		logic [7:0]  data;
		logic [7:0]  exp_val;
		logic [7:0]  tol;	// allowed distance from exp_val
		logic        rnd;	// lcg data that exp follows
	} row_t;

	row_t tbl [NROWS] = '{
		'{OP_LED,  16'h0000, 8'h00, 8'h3F, 8'd0, 1'b0},	// leds off after reset
		'{OP_RD,   16'h0006, 8'h00, 8'h0F, 8'd0, 1'b0},
		'{OP_WR,   16'h0000, 8'hC5, 8'h00, 8'd0, 1'b0},
		'{OP_LED,  16'h0000, 8'h00, 8'h3A, 8'd0, 1'b0},	// ~05h in six bits
		'{OP_WR,   16'h0006, 8'h00, 8'h00, 8'd0, 1'b1},
		'{OP_VOL,  16'h0000, 8'h00, 8'h00, 8'd0, 1'b1},
		'{OP_RD,   16'h0006, 8'h00, 8'h00, 8'd0, 1'b1},
		'{OP_WR,   16'h00A8, 8'hE4, 8'h00, 8'd0, 1'b0},	// page n in slot n
		'{OP_RD,   16'h00A8, 8'h00, 8'hE4, 8'd0, 1'b0},
		'{OP_MEM,  16'h0000, 8'h00, 8'h00, 8'd0, 1'b0},
		'{OP_MEM,  16'h4000, 8'h00, 8'h01, 8'd0, 1'b0},
		'{OP_MEM,  16'h8000, 8'h00, 8'h02, 8'd0, 1'b0},
		'{OP_MEM,  16'hC000, 8'h00, 8'h07, 8'd0, 1'b0},	// ram page
		'{OP_WR,   16'h00A8, 8'h1B, 8'h00, 8'd0, 1'b0},	// reversed order
		'{OP_MEM,  16'h0123, 8'h00, 8'h07, 8'd0, 1'b0},
		'{OP_MEM,  16'hFFFF, 8'h00, 8'h00, 8'd0, 1'b0},
		'{OP_WR,   16'h0001, 8'h00, 8'h00, 8'd0, 1'b0},	// clear tick count
		'{OP_IDLE, 16'd50,   8'h00, 8'h00, 8'd0, 1'b0},
		'{OP_RD,   16'h0001, 8'h00, 8'h05, 8'd1, 1'b0},
		'{OP_IDLE, 16'd2600, 8'h00, 8'h00, 8'd0, 1'b0},
		'{OP_RD,   16'h0001, 8'h00, 8'hFF, 8'd0, 1'b0},	// saturated
		'{OP_PSG,  16'h00A0, 8'h07, 8'd59, 8'd0, 1'b0},
		'{OP_PSG,  16'h00A0, 8'h08, 8'd0,  8'd0, 1'b0},	// lands in holdoff
		'{OP_RD,   16'h0055, 8'h00, 8'hFF, 8'd0, 1'b0}	// unmapped port
	};

	logic        clk;
	logic        rst_n;
	logic        iorq;
	logic        merq;
	logic        rd;
	logic        wr;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic [7:0]  rdata;
	logic        rd_valid;
	logic        busy;
	logic        ram_sel;
	slot_t       page_slot;
	logic [5:0]  led;
	logic [7:0]  mixvol;
	logic [31:0] lcg_state;
	logic [7:0]  last_rnd;	// latest random write data
	int          n_pass;
	int          n_fail;
	int          fails_before;

	tb_clock_gen #(.PERIOD_NS(100), .RST_CYCLES(3)) u_clk (.o_CLK(clk), .o_RST_n(rst_n));

	basic_slot_unit #(
		.TICK_DIV (10)
	) dut (
		.i_CLK (clk), .i_RST_n (rst_n), .i_iorq (iorq), .i_merq (merq),
		.i_rd (rd), .i_wr (wr), .i_addr (addr), .i_wdata (wdata),
		.o_rdata (rdata), .o_rd_valid (rd_valid), .o_busy (busy),
		.o_ram_sel (ram_sel), .o_page_slot (page_slot), .o_led (led), .o_mixvol (mixvol)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic wait_clocks(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;	// stay 1 ns past the edge
		end
	endtask

	task automatic compare_value(input int row, input string sig, input logic [7:0] got,
			input logic [7:0] want, input logic [7:0] tol);
		int diff;
		diff = (got > want) ? int'(got - want) : int'(want - got);
		if (diff > int'(tol)) begin
			$display("[FAIL] row %0d %s got %h expected %h", row, sig, got, want);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	// one strobe edge, dropped after E0
	task automatic io_cycle(input logic is_wr, input logic [15:0] a, input logic [7:0] d);
		iorq  = 1'b1;
		rd    = ~is_wr;
		wr    = is_wr;
		addr  = a;
		wdata = d;
		wait_clocks(1);
		iorq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
	endtask

	task automatic run_row(input int i);
		row_t       r;
		logic [7:0] d;
		logic [7:0] want;
		int         k;
		r    = tbl[i];
		d    = r.data;
		want = r.exp_val;
		if (r.rnd) begin
			if (r.op == OP_WR) begin
				lcg_state = lcg_next(lcg_state);
				last_rnd  = lcg_state[31:24];	// upper bits mix best
			end
			d    = last_rnd;
			want = last_rnd;	// volume kept as written
		end
		case (r.op)
			OP_WR: begin
				io_cycle(1'b1, r.arg, d);
				wait_clocks(2);	// through E1 and E2
			end
			OP_RD: begin
				io_cycle(1'b0, r.arg, 8'h00);
				k = 0;
				while (!rd_valid && k < 8) begin
					wait_clocks(1);
					k++;
				end
				if (!rd_valid) begin
					$display("row %0d: no read valid pulse within 8 clocks", i);
					n_fail++;
				end else begin
					compare_value(i, "o_rdata", rdata, want, r.tol);
				end
			end
			OP_LED: compare_value(i, "o_led", 8'(led), want, 8'd0);
			OP_VOL: compare_value(i, "o_mixvol", mixvol, want, 8'd0);
			OP_MEM: begin
				merq = 1'b1;
				addr = r.arg;
				wait_clocks(1);	// E0 takes the cycle
				merq = 1'b0;
				wait_clocks(1);	// E1 decodes the page
				compare_value(i, "o_page_slot", 8'(page_slot), 8'(want[1:0]), 8'd0);
				compare_value(i, "o_ram_sel", 8'(ram_sel), 8'(want[2]), 8'd0);
			end
			OP_IDLE: wait_clocks(int'(r.arg));
			OP_PSG: begin
				io_cycle(1'b1, r.arg, d);
				k = 0;
				while (!busy && k < 6) begin	// rise is due after E1
					wait_clocks(1);
					k++;
				end
				k = 0;
				while (busy && k < 200) begin
					k++;
					wait_clocks(1);
				end
				compare_value(i, "o_busy length", 8'(k), want, 8'd0);
			end
			default: begin
				$display("row %0d: unknown table operation %0d", i, r.op);
				n_fail++;
			end
		endcase
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the table was finished");
		$display("Errors found");
		$finish;
	end

	initial begin
		iorq      = 1'b0;
		merq      = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = '0;
		wdata     = '0;
		n_pass    = 0;
		n_fail    = 0;
		last_rnd  = '0;
		lcg_state = 32'hce4fe35c;
		@(posedge rst_n);
		wait_clocks(1);
		for (int i = 0; i < NROWS; i++) begin
			fails_before = n_fail;
			run_row(i);
			if (n_fail == fails_before) begin
				$display("row %0d op %0d passed", i, tbl[i].op);
			end else begin
				$display("row %0d op %0d failed", i, tbl[i].op);
			end
		end
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: build.f
source/slot_bus_pkg.sv
source/io_map_pkg.sv
source/bus_access_if.sv
source/bus_capture.sv
source/slot_mapper.sv
source/io_registers.sv
source/psg_wait_gen.sv
source/basic_slot_unit.sv
tests/tb_clock_gen.sv
tests/basic_slot_unit_assert.sv
tests/tb_basic_slot_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_basic_slot_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
